// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_soc_bus
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' src.f)
SIM  := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) soc_config.svh src.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f src.f

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "^TB PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== bus_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_config.svh"

module bus_arbiter (
  input  wire logic                    clk,
  input  wire logic                    rst,
  input  wire soc_bus_pkg::fetch_req_t fetch_req_i,
  input  wire soc_bus_pkg::load_req_t  load_req_i,
  input  wire soc_bus_pkg::store_req_t store_req_i,
  output soc_bus_pkg::mst_rsp_t        fetch_rsp_o,
  output soc_bus_pkg::mst_rsp_t        load_rsp_o,
  output soc_bus_pkg::mst_rsp_t        store_rsp_o,
  output soc_bus_pkg::axil_req_t       sram_req_o,
  output soc_bus_pkg::axil_req_t       uart_req_o,
  output soc_bus_pkg::axil_req_t       clint_req_o,
  input  wire soc_bus_pkg::axil_rsp_t  sram_rsp_i,
  input  wire soc_bus_pkg::axil_rsp_t  uart_rsp_i,
  input  wire soc_bus_pkg::axil_rsp_t  clint_rsp_i
);
  import soc_bus_pkg::*;

  typedef enum logic [1:0] {ST_IDLE, ST_ISSUE, ST_WAIT, ST_DECERR} state_e;
  typedef enum logic [1:0] {GNT_FETCH, GNT_LOAD, GNT_STORE} gnt_e;
  typedef enum logic [1:0] {TGT_SRAM, TGT_UART, TGT_CLINT, TGT_NONE} tgt_e;

  state_e    state_q;
  state_e    state_d;
  gnt_e      gnt_q;
  gnt_e      gnt_d;
  tgt_e      tgt_q;
  tgt_e      tgt_d;
  logic      any_req;
  addr_t     cur_addr;
  logic      cur_write;
  axil_req_t slv_req;
  axil_rsp_t slv_rsp;
  logic      slv_accept;
  logic      slv_done;
  mst_rsp_t  rsp;

  // target of one access; fetch only from sram, no console loads,
  // mtime is read-only
  function automatic tgt_e decode(addr_t a, gnt_e g);
    addr_t off;
    tgt_e  t;
    off = a - `SOC_SRAM_BASE;
    t = TGT_NONE;
    if (off < (`SOC_SRAM_WORDS * 4)) begin
      t = TGT_SRAM;
    end else if (g == GNT_STORE && a == `SOC_UART_ADDR) begin
      t = TGT_UART;
    end else if (g != GNT_FETCH &&
                 (a == `SOC_CLINT_MTIMECMP_LO || a == `SOC_CLINT_MTIMECMP_HI)) begin
      t = TGT_CLINT;
    end else if (g == GNT_LOAD &&
                 (a == `SOC_CLINT_MTIME_LO || a == `SOC_CLINT_MTIME_HI)) begin
      t = TGT_CLINT;
    end
    return t;
  endfunction

  assign any_req = fetch_req_i.valid || load_req_i.valid || store_req_i.valid;

  // lsu wins over ifu when both wait in idle
  always_comb begin
    gnt_d = GNT_FETCH;
    tgt_d = decode(fetch_req_i.addr, GNT_FETCH);
    if (store_req_i.valid) begin
      gnt_d = GNT_STORE;
      tgt_d = decode(store_req_i.addr, GNT_STORE);
    end else if (load_req_i.valid) begin
      gnt_d = GNT_LOAD;
      tgt_d = decode(load_req_i.addr, GNT_LOAD);
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (any_req) begin
          state_d = ST_ISSUE;
        end
      end
      ST_ISSUE: begin
        if (tgt_q == TGT_NONE) begin
          state_d = ST_DECERR;
        end else if (slv_accept) begin
          state_d = ST_WAIT;
        end
      end
      ST_WAIT: begin
        if (slv_done) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= ST_IDLE;
      gnt_q   <= GNT_FETCH;
      tgt_q   <= TGT_NONE;
    end else begin
      state_q <= state_d;
      // grant is only taken in idle, never preempted
      if (state_q == ST_IDLE && any_req) begin
        gnt_q <= gnt_d;
        tgt_q <= tgt_d;
      end
    end
  end

  // masters hold their fields, so the granted one is read directly
  assign cur_write = (gnt_q == GNT_STORE);

  always_comb begin
    case (gnt_q)
      GNT_STORE: cur_addr = store_req_i.addr;
      GNT_LOAD:  cur_addr = load_req_i.addr;
      default:   cur_addr = fetch_req_i.addr;
    endcase
  end

  always_comb begin
    slv_req = '0;
    if (state_q == ST_ISSUE) begin
      if (cur_write) begin
        slv_req.aw_valid = 1'b1;
        slv_req.aw_addr  = cur_addr;
        slv_req.w_valid  = 1'b1;
        slv_req.w_data   = store_req_i.data;
        slv_req.w_strb   = store_req_i.strb;
      end else begin
        slv_req.ar_valid = 1'b1;
        slv_req.ar_addr  = cur_addr;
      end
    end
  end

  // one slave sees the request, its channel comes back
  always_comb begin
    sram_req_o  = '0;
    uart_req_o  = '0;
    clint_req_o = '0;
    slv_rsp     = '0;
    case (tgt_q)
      TGT_SRAM: begin
        sram_req_o = slv_req;
        slv_rsp    = sram_rsp_i;
      end
      TGT_UART: begin
        uart_req_o = slv_req;
        slv_rsp    = uart_rsp_i;
      end
      TGT_CLINT: begin
        clint_req_o = slv_req;
        slv_rsp     = clint_rsp_i;
      end
      default: slv_rsp = '0;
    endcase
  end

  assign slv_accept = cur_write ? (slv_rsp.aw_ready && slv_rsp.w_ready) : slv_rsp.ar_ready;
  assign slv_done   = cur_write ? slv_rsp.b_valid : slv_rsp.r_valid;

  always_comb begin
    rsp = '0;
    if (state_q == ST_DECERR) begin
      rsp.valid = 1'b1;
      rsp.resp  = RESP_DECERR;
    end else if (state_q == ST_WAIT && slv_done) begin
      rsp.valid = 1'b1;
      rsp.data  = cur_write ? '0 : slv_rsp.r_data;
      rsp.resp  = cur_write ? slv_rsp.b_resp : slv_rsp.r_resp;
    end
  end

  always_comb begin
    fetch_rsp_o = '0;
    load_rsp_o  = '0;
    store_rsp_o = '0;
    case (gnt_q)
      GNT_STORE: store_rsp_o = rsp;
      GNT_LOAD:  load_rsp_o  = rsp;
      default:   fetch_rsp_o = rsp;
    endcase
  end

endmodule

`default_nettype wire

// ==== clint_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_config.svh"

module clint_timer (
  input  wire logic                   clk,
  input  wire logic                   rst,
  input  wire soc_bus_pkg::axil_req_t req_i,
  output soc_bus_pkg::axil_rsp_t      rsp_o,
  output logic                        timer_irq_o
);
  import soc_bus_pkg::*;

  logic [63:0] mtime_q;
  logic [63:0] mtimecmp_q;
  logic        irq_q;
  logic        rd_fire;
  logic        wr_fire;
  logic        r_valid_q;
  logic        b_valid_q;
  data_t       r_data_q;
  resp_t       r_resp_q;
  resp_t       b_resp_q;
  data_t       rd_word;
  resp_t       rd_resp;
  resp_t       wr_resp;

  assign rd_fire = req_i.ar_valid;
  assign wr_fire = req_i.aw_valid && req_i.w_valid;

  always_comb begin
    rd_resp = RESP_OKAY;
    case (req_i.ar_addr)
      `SOC_CLINT_MTIME_LO:    rd_word = mtime_q[31:0];
      `SOC_CLINT_MTIME_HI:    rd_word = mtime_q[63:32];
      `SOC_CLINT_MTIMECMP_LO: rd_word = mtimecmp_q[31:0];
      `SOC_CLINT_MTIMECMP_HI: rd_word = mtimecmp_q[63:32];
      default: begin
        rd_word = '0;
        rd_resp = RESP_DECERR;
      end
    endcase
  end

  // only the compare halves take writes
  assign wr_resp = (req_i.aw_addr == `SOC_CLINT_MTIMECMP_LO ||
                    req_i.aw_addr == `SOC_CLINT_MTIMECMP_HI) ? RESP_OKAY : RESP_DECERR;

  always_ff @(posedge clk) begin
    if (rst) begin
      mtime_q    <= '0;
      mtimecmp_q <= `SOC_CLINT_MTIMECMP_RST;
      irq_q      <= 1'b0;
    end else begin
      mtime_q <= mtime_q + 64'd1;
      irq_q   <= (mtime_q >= mtimecmp_q);
      if (wr_fire) begin
        for (int b = 0; b < 4; b++) begin
          if (req_i.w_strb[b] && req_i.aw_addr == `SOC_CLINT_MTIMECMP_LO) begin
            mtimecmp_q[8*b +: 8] <= req_i.w_data[8*b +: 8];
          end else if (req_i.w_strb[b] && req_i.aw_addr == `SOC_CLINT_MTIMECMP_HI) begin
            mtimecmp_q[32 + 8*b +: 8] <= req_i.w_data[8*b +: 8];
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_fire) begin
      r_data_q <= rd_word;
      r_resp_q <= rd_resp;
    end
    if (wr_fire) begin
      b_resp_q <= wr_resp;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      r_valid_q <= 1'b0;
      b_valid_q <= 1'b0;
    end else begin
      r_valid_q <= rd_fire;
      b_valid_q <= wr_fire;
    end
  end

  assign timer_irq_o = irq_q;

  always_comb begin
    rsp_o          = '0;
    rsp_o.ar_ready = 1'b1;
    rsp_o.aw_ready = 1'b1;
    rsp_o.w_ready  = 1'b1;
    rsp_o.r_valid  = r_valid_q;
    rsp_o.r_data   = r_data_q;
    rsp_o.r_resp   = r_resp_q;
    rsp_o.b_valid  = b_valid_q;
    rsp_o.b_resp   = b_resp_q;
  end

endmodule

`default_nettype wire

// ==== mem_sram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_config.svh"

module mem_sram (
  input  wire logic                   clk,
  input  wire logic                   rst,
  input  wire soc_bus_pkg::axil_req_t req_i,
  output soc_bus_pkg::axil_rsp_t      rsp_o
);
  import soc_bus_pkg::*;

  localparam int IDX_W = $clog2(`SOC_SRAM_WORDS);

  data_t            mem [`SOC_SRAM_WORDS];
  addr_t            rd_off;
  addr_t            wr_off;
  logic [IDX_W-1:0] rd_idx;
  logic [IDX_W-1:0] wr_idx;
  logic             rd_fire;
  logic             wr_fire;
  logic             r_valid_q;
  logic             b_valid_q;
  data_t            r_data_q;

  // word index relative to the sram base
  assign rd_off = req_i.ar_addr - `SOC_SRAM_BASE;
  assign wr_off = req_i.aw_addr - `SOC_SRAM_BASE;
  assign rd_idx = rd_off[IDX_W+1:2];
  assign wr_idx = wr_off[IDX_W+1:2];

  // ready is always high, so valid alone fires
  assign rd_fire = req_i.ar_valid;
  assign wr_fire = req_i.aw_valid && req_i.w_valid;

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      for (int b = 0; b < 4; b++) begin
        if (req_i.w_strb[b]) begin
          mem[wr_idx][8*b +: 8] <= req_i.w_data[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_fire) begin
      r_data_q <= mem[rd_idx];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      r_valid_q <= 1'b0;
      b_valid_q <= 1'b0;
    end else begin
      r_valid_q <= rd_fire;
      b_valid_q <= wr_fire;
    end
  end

  always_comb begin
    rsp_o          = '0;
    rsp_o.ar_ready = 1'b1;
    rsp_o.aw_ready = 1'b1;
    rsp_o.w_ready  = 1'b1;
    rsp_o.r_valid  = r_valid_q;
    rsp_o.r_data   = r_data_q;
    rsp_o.r_resp   = RESP_OKAY;
    rsp_o.b_valid  = b_valid_q;
    rsp_o.b_resp   = RESP_OKAY;
  end

endmodule

`default_nettype wire

// ==== soc_bus_pkg.sv ====
`default_nettype none

package soc_bus_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_DECERR = 2'b11
  } resp_t;

  // master side, request held until the response pulse
  typedef struct packed {
    logic  valid;
    addr_t addr;
  } fetch_req_t;

  typedef struct packed {
    logic  valid;
    addr_t addr;
  } load_req_t;

  typedef struct packed {
    logic  valid;
    addr_t addr;
    data_t data;
    strb_t strb;
  } store_req_t;

  typedef struct packed {
    logic  valid;
    data_t data;
    resp_t resp;
  } mst_rsp_t;

  // single-beat axi4-lite, r_ready and b_ready implied high
  typedef struct packed {
    logic  ar_valid;
    addr_t ar_addr;
    logic  aw_valid;
    addr_t aw_addr;
    logic  w_valid;
    data_t w_data;
    strb_t w_strb;
  } axil_req_t;

  typedef struct packed {
    logic  ar_ready;
    logic  r_valid;
    data_t r_data;
    resp_t r_resp;
    logic  aw_ready;
    logic  w_ready;
    logic  b_valid;
    resp_t b_resp;
  } axil_rsp_t;

  typedef struct packed {
    logic       valid;
    logic [7:0] ch;
  } uart_char_t;

endpackage

`default_nettype wire

// ==== soc_bus_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_bus_properties (
  input wire logic                    clk,
  input wire logic                    rst,
  input wire soc_bus_pkg::fetch_req_t fetch_req_i,
  input wire soc_bus_pkg::load_req_t  load_req_i,
  input wire soc_bus_pkg::store_req_t store_req_i,
  input wire soc_bus_pkg::mst_rsp_t   fetch_rsp_o,
  input wire soc_bus_pkg::mst_rsp_t   load_rsp_o,
  input wire soc_bus_pkg::mst_rsp_t   store_rsp_o,
  input wire soc_bus_pkg::axil_req_t  sram_req_o,
  input wire soc_bus_pkg::axil_req_t  uart_req_o,
  input wire soc_bus_pkg::axil_req_t  clint_req_o
);
  import soc_bus_pkg::*;

  logic [2:0] slv_valid;
  logic       mst_valid;

  assign slv_valid = {sram_req_o.ar_valid | sram_req_o.aw_valid,
                      uart_req_o.ar_valid | uart_req_o.aw_valid,
                      clint_req_o.ar_valid | clint_req_o.aw_valid};
  assign mst_valid = fetch_req_i.valid || load_req_i.valid || store_req_i.valid;

  // one slave at a time, and only for a waiting master
  a_one_slave: assert property (@(posedge clk) disable iff (rst)
    $onehot0(slv_valid) && (slv_valid == 3'b000 || mst_valid))
    else $error("slave request with more than one target or no master waiting");

  a_fetch_hold: assert property (@(posedge clk) disable iff (rst)
    fetch_req_i.valid && !fetch_rsp_o.valid |=> $stable(fetch_req_i))
    else $error("fetch request changed before its response");
  a_load_hold: assert property (@(posedge clk) disable iff (rst)
    load_req_i.valid && !load_rsp_o.valid |=> $stable(load_req_i))
    else $error("load request changed before its response");
  a_store_hold: assert property (@(posedge clk) disable iff (rst)
    store_req_i.valid && !store_rsp_o.valid |=> $stable(store_req_i))
    else $error("store request changed before its response");

  a_fetch_rsp_req: assert property (@(posedge clk) disable iff (rst)
    fetch_rsp_o.valid |-> $past(fetch_req_i.valid))
    else $error("fetch response without a request");
  a_load_rsp_req: assert property (@(posedge clk) disable iff (rst)
    load_rsp_o.valid |-> $past(load_req_i.valid))
    else $error("load response without a request");
  a_store_rsp_req: assert property (@(posedge clk) disable iff (rst)
    store_rsp_o.valid |-> $past(store_req_i.valid))
    else $error("store response without a request");

  a_rsp_pulse: assert property (@(posedge clk) disable iff (rst)
    fetch_rsp_o.valid || load_rsp_o.valid || store_rsp_o.valid |=>
    !fetch_rsp_o.valid && !load_rsp_o.valid && !store_rsp_o.valid)
    else $error("response valid held longer than one cycle");

endmodule

bind bus_arbiter soc_bus_properties soc_bus_properties_inst (
  .clk         (clk),
  .rst         (rst),
  .fetch_req_i (fetch_req_i),
  .load_req_i  (load_req_i),
  .store_req_i (store_req_i),
  .fetch_rsp_o (fetch_rsp_o),
  .load_rsp_o  (load_rsp_o),
  .store_rsp_o (store_rsp_o),
  .sram_req_o  (sram_req_o),
  .uart_req_o  (uart_req_o),
  .clint_req_o (clint_req_o)
);

`default_nettype wire

// ==== soc_bus_tests.txt ====
# op addr data strb resp mode, all hex; W waits data cycles, I expects timer_irq_o = data
# mode: S 1 = random data; F/L 0 = scoreboard, 1 = data column, 2 = mtime step; P data = fetch addr
I 0 0 0 0 0
S 80000000 11223344 f 0 0
L 80000000 0 0 0 0
F 80000000 0 0 0 0
S 80000000 aabbccdd 3 0 0
L 80000000 0 0 0 0
S 80000004 0 f 0 1
S 80000008 cafef00d f 0 0
S 800003fc 5a5a5a5a f 0 0
S 800003fc 0000a500 2 0 0
P 80000004 80000008 0 0 0
L 800003fc 0 0 0 0
F 80000004 0 0 0 0
S a00003f8 48 1 0 0
S a00003f8 69 1 0 0
S a00003f8 2100 2 0 0
L a0000048 0 0 0 2
W 0 a 0 0 0
L a0000048 0 0 0 2
W 0 5 0 0 0
L a0000048 0 0 0 2
F a00003f8 0 0 3 1
L 10000000 0 0 3 1
L a00003f8 0 0 3 1
S a0000048 1 f 3 0
S a0000054 0 f 0 0
S a0000050 20 f 0 0
I 0 1 0 0 0
L a0000050 20 0 0 1
S a0000054 ffffffff f 0 0
I 0 0 0 0 0

// ==== soc_bus_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_bus_top (
  input  wire logic                    clk,
  input  wire logic                    rst,
  input  wire soc_bus_pkg::fetch_req_t fetch_req_i,
  input  wire soc_bus_pkg::load_req_t  load_req_i,
  input  wire soc_bus_pkg::store_req_t store_req_i,
  output soc_bus_pkg::mst_rsp_t        fetch_rsp_o,
  output soc_bus_pkg::mst_rsp_t        load_rsp_o,
  output soc_bus_pkg::mst_rsp_t        store_rsp_o,
  output soc_bus_pkg::uart_char_t      uart_char_o,
  output logic                         timer_irq_o
);
  import soc_bus_pkg::*;

  axil_req_t sram_req;
  axil_req_t uart_req;
  axil_req_t clint_req;
  axil_rsp_t sram_rsp;
  axil_rsp_t uart_rsp;
  axil_rsp_t clint_rsp;

  bus_arbiter bus_arbiter_inst (
    .clk         (clk),
    .rst         (rst),
    .fetch_req_i (fetch_req_i),
    .load_req_i  (load_req_i),
    .store_req_i (store_req_i),
    .fetch_rsp_o (fetch_rsp_o),
    .load_rsp_o  (load_rsp_o),
    .store_rsp_o (store_rsp_o),
    .sram_req_o  (sram_req),
    .uart_req_o  (uart_req),
    .clint_req_o (clint_req),
    .sram_rsp_i  (sram_rsp),
    .uart_rsp_i  (uart_rsp),
    .clint_rsp_i (clint_rsp)
  );

  mem_sram mem_sram_inst (
    .clk   (clk),
    .rst   (rst),
    .req_i (sram_req),
    .rsp_o (sram_rsp)
  );

  uart_sink uart_sink_inst (
    .clk    (clk),
    .rst    (rst),
    .req_i  (uart_req),
    .rsp_o  (uart_rsp),
    .char_o (uart_char_o)
  );

  clint_timer clint_timer_inst (
    .clk         (clk),
    .rst         (rst),
    .req_i       (clint_req),
    .rsp_o       (clint_rsp),
    .timer_irq_o (timer_irq_o)
  );

endmodule

`default_nettype wire

// ==== soc_config.svh ====
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// on-chip sram window
`define SOC_SRAM_BASE 32'h8000_0000
`define SOC_SRAM_WORDS 256

// console data register, byte stores only
`define SOC_UART_ADDR 32'ha000_03f8

// core-local timer registers, low and high halves
`define SOC_CLINT_MTIME_LO 32'ha000_0048
`define SOC_CLINT_MTIME_HI 32'ha000_004c
`define SOC_CLINT_MTIMECMP_LO 32'ha000_0050
`define SOC_CLINT_MTIMECMP_HI 32'ha000_0054

// compare value that keeps the timer interrupt off
`define SOC_CLINT_MTIMECMP_RST 64'hffff_ffff_ffff_ffff

`endif

// ==== src.f ====
+incdir+.
soc_bus_pkg.sv
bus_arbiter.sv
mem_sram.sv
uart_sink.sv
clint_timer.sv
soc_bus_top.sv
soc_bus_properties.sv
tb_soc_bus.sv

// ==== tb_soc_bus.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_config.svh"

module tb_soc_bus;
  import soc_bus_pkg::*;

  logic       clk;
  logic       rst;
  fetch_req_t fetch_req;
  load_req_t  load_req;
  store_req_t store_req;
  mst_rsp_t   fetch_rsp;
  mst_rsp_t   load_rsp;
  mst_rsp_t   store_rsp;
  uart_char_t uart_char;
  logic       timer_irq;

  // test table as read from the file
  byte        op_q[$];
  addr_t      addr_q[$];
  data_t      data_q[$];
  strb_t      strb_q[$];
  logic [1:0] resp_q[$];
  int         mode_q[$];

  // sram scoreboard and console characters
  data_t      sb [`SOC_SRAM_WORDS];
  logic       sb_known [`SOC_SRAM_WORDS];
  byte        exp_chars[$];
  byte        got_chars[$];

  int         cycles = 0;
  int         limit = 0;
  int         test_errs = 0;
  int         failed_tests = 0;
  int         seed = 32'hd2fc;
  int         w_gap = 0;
  data_t      prev_mtime = '0;
  logic       have_mtime = 1'b0;

  soc_bus_top soc_bus_top_inst (
    .clk         (clk),
    .rst         (rst),
    .fetch_req_i (fetch_req),
    .load_req_i  (load_req),
    .store_req_i (store_req),
    .fetch_rsp_o (fetch_rsp),
    .load_rsp_o  (load_rsp),
    .store_rsp_o (store_rsp),
    .uart_char_o (uart_char),
    .timer_irq_o (timer_irq)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("timeout: run did not finish within %0d cycles", limit);
      $display("TB FAILED");
      $finish;
    end
  end

  always @(negedge clk) begin
    if (!rst && uart_char.valid) begin
      got_chars.push_back(uart_char.ch);
    end
  end

  task automatic check_data(input string name, input data_t got, input data_t exp);
    assert (got === exp) else begin
      $display("Mismatch %s: got %h expected %h", name, got, exp);
      test_errs++;
    end
  endtask

  function automatic int sram_index(input addr_t a);
    addr_t off;
    off = a - `SOC_SRAM_BASE;
    return int'(off >> 2) % `SOC_SRAM_WORDS;
  endfunction

  // data check by mode: scoreboard, literal, mtime step, none
  task automatic check_read(input string name, input mst_rsp_t r, input addr_t a,
                            input logic [1:0] er, input int mode, input data_t d);
    int idx;
    idx = sram_index(a);
    check_data({name, ".resp"}, 32'(r.resp), 32'(er));
    case (mode)
      0: begin
        assert (sb_known[idx]) else begin
          $display("%s read sram word at %h that no full-word store wrote", name, a);
          test_errs++;
        end
        if (sb_known[idx]) begin
          check_data({name, ".data"}, r.data, sb[idx]);
        end
      end
      1: check_data({name, ".data"}, r.data, d);
      2: begin
        if (have_mtime) begin
          assert (r.data > prev_mtime && (r.data - prev_mtime) >= data_t'(w_gap)) else begin
            $display("Mismatch %s.data: got %h after %h with gap %0d",
                     name, r.data, prev_mtime, w_gap);
            test_errs++;
          end
        end
        prev_mtime = r.data;
        have_mtime = 1'b1;
        w_gap = 0;
      end
      default: ;
    endcase
  endtask

  task automatic single_access(input byte op, input addr_t a, input data_t d,
                               input strb_t s, output mst_rsp_t r);
    @(posedge clk);
    if (op == "F") begin
      fetch_req.valid <= 1'b1;
      fetch_req.addr  <= a;
    end else if (op == "L") begin
      load_req.valid <= 1'b1;
      load_req.addr  <= a;
    end else begin
      store_req.valid <= 1'b1;
      store_req.addr  <= a;
      store_req.data  <= d;
      store_req.strb  <= s;
    end
    r = '0;
    while (!r.valid) begin
      @(negedge clk);
      if (op == "F") r = fetch_rsp;
      else if (op == "L") r = load_rsp;
      else r = store_rsp;
    end
    @(posedge clk);
    fetch_req.valid <= 1'b0;
    load_req.valid  <= 1'b0;
    store_req.valid <= 1'b0;
  endtask

  // fetch and load raised together, load must be served first
  task automatic parallel_access(input addr_t la, input addr_t fa);
    mst_rsp_t lr;
    mst_rsp_t fr;
    logic     got_l;
    logic     got_f;
    int       l_at;
    int       f_at;
    got_l = 1'b0;
    got_f = 1'b0;
    l_at = 0;
    f_at = 0;
    @(posedge clk);
    load_req.valid  <= 1'b1;
    load_req.addr   <= la;
    fetch_req.valid <= 1'b1;
    fetch_req.addr  <= fa;
    while (!(got_l && got_f)) begin
      @(negedge clk);
      if (load_rsp.valid && !got_l) begin
        got_l = 1'b1;
        lr = load_rsp;
        l_at = cycles;
      end
      if (fetch_rsp.valid && !got_f) begin
        got_f = 1'b1;
        fr = fetch_rsp;
        f_at = cycles;
      end
      @(posedge clk);
      if (got_l) load_req.valid <= 1'b0;
      if (got_f) fetch_req.valid <= 1'b0;
    end
    assert (l_at < f_at) else begin
      $display("fetch response came before the load response");
      test_errs++;
    end
    check_read("load_rsp_o", lr, la, 2'(RESP_OKAY), 0, '0);
    check_read("fetch_rsp_o", fr, fa, 2'(RESP_OKAY), 0, '0);
  endtask

  task automatic wait_irq(input logic level);
    int n;
    n = 0;
    @(negedge clk);
    while (timer_irq !== level && n < 16) begin
      @(negedge clk);
      n++;
    end
    assert (timer_irq === level) else begin
      $display("timer_irq_o did not settle at %0d within 16 cycles", level);
      test_errs++;
    end
  endtask

  initial begin
    int         fd;
    int         n;
    int         w_sum;
    int         idx;
    string      tok;
    string      rest;
    addr_t      a;
    data_t      d;
    strb_t      s;
    logic [1:0] r;
    int         m;
    byte        ch;
    mst_rsp_t   rsp;
    fetch_req = '0;
    load_req  = '0;
    store_req = '0;
    rst       = 1'b1;
    w_sum     = 0;
    for (int i = 0; i < `SOC_SRAM_WORDS; i++) begin
      sb_known[i] = 1'b0;
    end
    fd = $fopen("soc_bus_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open soc_bus_tests.txt");
      failed_tests++;
    end else begin
      while (!$feof(fd)) begin
        n = $fscanf(fd, "%s", tok);
        if (n == 1) begin
          if (tok.getc(0) == 8'h23) begin
            n = $fgets(rest, fd);
          end else begin
            n = $fscanf(fd, " %h %h %h %h %h", a, d, s, r, m);
            op_q.push_back(tok.getc(0));
            addr_q.push_back(a);
            data_q.push_back(d);
            strb_q.push_back(s);
            resp_q.push_back(r);
            mode_q.push_back(m);
            if (tok.getc(0) == "W") w_sum += d;
          end
        end
      end
      $fclose(fd);
    end
    limit = op_q.size() * 8 + w_sum + 50;

    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    assert (!fetch_rsp.valid && !load_rsp.valid && !store_rsp.valid &&
            !uart_char.valid && !timer_irq) else begin
      $display("outputs not low after reset");
      failed_tests++;
    end

    foreach (op_q[t]) begin
      test_errs = 0;
      case (op_q[t])
        "F", "L": begin
          single_access(op_q[t], addr_q[t], data_q[t], strb_q[t], rsp);
          check_read(op_q[t] == "F" ? "fetch_rsp_o" : "load_rsp_o", rsp, addr_q[t],
                     resp_q[t], mode_q[t], data_q[t]);
        end
        "S": begin
          d = (mode_q[t] == 1) ? $random(seed) : data_q[t];
          single_access("S", addr_q[t], d, strb_q[t], rsp);
          check_data("store_rsp_o.resp", 32'(rsp.resp), 32'(resp_q[t]));
          if (resp_q[t] == 2'(RESP_OKAY) && (addr_q[t] - `SOC_SRAM_BASE) <
              `SOC_SRAM_WORDS * 4) begin
            idx = sram_index(addr_q[t]);
            for (int b = 0; b < 4; b++) begin
              if (strb_q[t][b]) sb[idx][8*b +: 8] = d[8*b +: 8];
            end
            sb_known[idx] = sb_known[idx] || (strb_q[t] == 4'hf);
          end
          if (addr_q[t] == `SOC_UART_ADDR) begin
            // lowest enabled lane holds the character
            ch = d[7:0];
            for (int b = 3; b >= 0; b--) begin
              if (strb_q[t][b]) ch = d[8*b +: 8];
            end
            exp_chars.push_back(ch);
          end
        end
        "P": parallel_access(addr_q[t], data_q[t]);
        "I": wait_irq(data_q[t][0]);
        "W": begin
          repeat (data_q[t]) @(posedge clk);
          w_gap += data_q[t];
        end
        default: begin
          $display("unknown operation in test %0d", t);
          test_errs++;
        end
      endcase
      if (test_errs > 0) failed_tests++;
      $display("test %0d op %c: %s", t, op_q[t], test_errs > 0 ? "fail" : "ok");
    end

    assert (got_chars.size() == exp_chars.size()) else begin
      $display("console produced %0d characters, %0d expected",
               got_chars.size(), exp_chars.size());
      failed_tests++;
    end
    foreach (exp_chars[i]) begin
      if (i < got_chars.size()) begin
        assert (got_chars[i] == exp_chars[i]) else begin
          $display("Mismatch uart_char_o.ch[%0d]: got %h expected %h",
                   i, got_chars[i], exp_chars[i]);
          failed_tests++;
        end
      end
    end

    $display("tests %0d, failed %0d", op_q.size(), failed_tests);
    if (failed_tests == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== uart_sink.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_sink (
  input  wire logic                   clk,
  input  wire logic                   rst,
  input  wire soc_bus_pkg::axil_req_t req_i,
  output soc_bus_pkg::axil_rsp_t      rsp_o,
  output soc_bus_pkg::uart_char_t     char_o
);
  import soc_bus_pkg::*;

  logic       wr_fire;
  logic [7:0] lane_byte;
  logic       char_valid_q;
  logic [7:0] char_q;
  logic       r_valid_q;

  assign wr_fire = req_i.aw_valid && req_i.w_valid;

  // lowest enabled byte lane carries the character
  always_comb begin
    lane_byte = req_i.w_data[7:0];
    for (int b = 3; b >= 0; b--) begin
      if (req_i.w_strb[b]) begin
        lane_byte = req_i.w_data[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      char_q <= lane_byte;
    end
  end

  // char event and b response leave together
  always_ff @(posedge clk) begin
    if (rst) begin
      char_valid_q <= 1'b0;
      r_valid_q    <= 1'b0;
    end else begin
      char_valid_q <= wr_fire;
      r_valid_q    <= req_i.ar_valid;
    end
  end

  always_comb begin
    char_o.valid   = char_valid_q;
    char_o.ch      = char_q;
    rsp_o          = '0;
    rsp_o.ar_ready = 1'b1;
    rsp_o.aw_ready = 1'b1;
    rsp_o.w_ready  = 1'b1;
    rsp_o.b_valid  = char_valid_q;
    rsp_o.b_resp   = RESP_OKAY;
    // write-only device
    rsp_o.r_valid  = r_valid_q;
    rsp_o.r_resp   = RESP_DECERR;
  end

endmodule

`default_nettype wire
